/* compile.f */
verilog/oldland_pkg.sv
verilog/oldland_regfile.sv
verilog/oldland_decode.sv
verilog/oldland_exec.sv
verilog/oldland_result.sv
verilog/oldland_core.sv
verif/oldland_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module oldland_tb

output=$(./obj_dir/Voldland_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "all tests passed"; then
	exit 0
fi
exit 1

/* verif/oldland_tb.sv */
`timescale 1ns/1ps

module oldland_tb
	import oldland_pkg::*;
;

	// Expected outcome of one instruction.
	typedef enum {
		KIND_NO,	// No writeback and no taken branch.
		KIND_WR,	// Register write only.
		KIND_BR,	// Taken branch only.
		KIND_CALL	// Taken branch and a write of the return address.
	} kind_t;

	typedef struct {
		logic [31:0]          instr;
		logic [31:0]          pc;
		kind_t                kind;
		logic [reg_sel_w-1:0] rd;
		logic [31:0]          value;
		logic [31:0]          target;
	} entry_t;

	logic                 clk;
	logic                 rst_n;
	logic                 instr_valid;
	logic [31:0]          instr;
	logic [31:0]          pc;
	logic                 wb_en;
	logic [reg_sel_w-1:0] wb_sel;
	logic [31:0]          wb_val;
	logic                 branch_taken;
	logic [31:0]          branch_target;

	entry_t entries[$];
	int     cycles = 0;

	oldland_core #(.MEM_WORDS(64)) i_oldland_core (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= 6 * entries.size() + 100) begin
			$display("ERROR: the run did not finish within %0d cycles", cycles);
			stop_run();
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_run();
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] encode(input instr_class_t cls, input logic [3:0] op,
			input logic [2:0] rd, input logic [2:0] ra, input logic [2:0] rb,
			input logic use_rb, input logic [15:0] imm);
		return {cls, op, rd, ra, rb, use_rb, imm};
	endfunction

	task automatic add_entry(input logic [31:0] word, input logic [31:0] addr, input kind_t kind,
			input logic [reg_sel_w-1:0] rd, input logic [31:0] value, input logic [31:0] target);
		entry_t e;
		e.instr  = word;
		e.pc     = addr;
		e.kind   = kind;
		e.rd     = rd;
		e.value  = value;
		e.target = target;
		entries.push_back(e);
	endtask

	task automatic check_write(input logic [reg_sel_w-1:0] sel, input logic [31:0] val,
			input logic [reg_sel_w-1:0] exp_sel, input logic [31:0] exp_val);
		if (sel !== exp_sel) begin
			$display("FAILED at %0t: wb_sel got %0d expected %0d", $time, sel, exp_sel);
			stop_run();
		end
		if (val !== exp_val) begin
			$display("FAILED at %0t: wb_val got %h expected %h", $time, val, exp_val);
			stop_run();
		end
	endtask

	task automatic check_branch(input logic taken, input logic [31:0] target,
			input logic exp_taken, input logic [31:0] exp_target);
		if (taken !== exp_taken) begin
			$display("FAILED at %0t: branch_taken got %b expected %b", $time, taken, exp_taken);
			stop_run();
		end
		if (target !== exp_target) begin
			$display("FAILED at %0t: branch_target got %h expected %h", $time, target, exp_target);
			stop_run();
		end
	endtask

	task automatic check_quiet();
		if (wb_en !== 1'b0 || branch_taken !== 1'b0) begin
			$display("ERROR at %0t: wb_en or branch_taken is not low while idle", $time);
			stop_run();
		end
	endtask

	////////////////////
	// Instruction table
	////////////////////

	task automatic build_entries();
		// Constants, then register arithmetic on r1 = 0x1234, r2 = -2, r3 = 5.
		add_entry(encode(CLASS_ARITH, ALU_MOV, 1, 0, 0, 0, 'h1234), 0, KIND_WR, 1, 'h1234, 0);
		add_entry(encode(CLASS_ARITH, ALU_MOV, 2, 0, 0, 0, 'hfffe), 0, KIND_WR, 2, 'hfffffffe, 0);
		add_entry(encode(CLASS_ARITH, ALU_MOV, 3, 0, 0, 0, 'h0005), 0, KIND_WR, 3, 'h5, 0);
		add_entry(encode(CLASS_ARITH, ALU_ADD, 4, 1, 3, 1, 'h0000), 0, KIND_WR, 4, 'h1239, 0);
		add_entry(encode(CLASS_ARITH, ALU_SUB, 5, 1, 0, 0, 'h0034), 0, KIND_WR, 5, 'h1200, 0);
		add_entry(encode(CLASS_ARITH, ALU_AND, 4, 1, 0, 0, 'h0ff0), 0, KIND_WR, 4, 'h0230, 0);
		add_entry(encode(CLASS_ARITH, ALU_OR, 5, 1, 0, 0, 'h8000), 0, KIND_WR, 5, 'hffff9234, 0);
		add_entry(encode(CLASS_ARITH, ALU_XOR, 6, 1, 2, 1, 'h0000), 0, KIND_WR, 6, 'hffffedca, 0);
		add_entry(encode(CLASS_ARITH, ALU_LSL, 4, 1, 3, 1, 'h0000), 0, KIND_WR, 4, 'h24680, 0);
		add_entry(encode(CLASS_ARITH, ALU_LSR, 5, 2, 0, 0, 'h0004), 0, KIND_WR, 5, 'h0fffffff, 0);
		add_entry(encode(CLASS_ARITH, ALU_ASR, 6, 2, 0, 0, 'h0001), 0, KIND_WR, 6, 'hffffffff, 0);
		add_entry(encode(CLASS_ARITH, ALU_BIC, 4, 1, 0, 0, 'h0002), 0, KIND_WR, 4, 'h1230, 0);
		add_entry(encode(CLASS_ARITH, ALU_BST, 5, 1, 0, 0, 'h0000), 0, KIND_WR, 5, 'h1235, 0);
		add_entry(encode(CLASS_ARITH, ALU_PASS, 6, 1, 0, 0, 'h0000), 0, KIND_WR, 6, 'h1234, 0);
		// A borrow from 5 - 0x1234 sets carry, which ADDC and SUBC then add in.
		add_entry(encode(CLASS_ARITH, ALU_CMP, 0, 3, 1, 1, 'h0000), 0, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_ARITH, ALU_ADDC, 4, 1, 3, 1, 'h0000), 0, KIND_WR, 4, 'h123a, 0);
		add_entry(encode(CLASS_ARITH, ALU_SUBC, 5, 1, 0, 0, 'h0004), 0, KIND_WR, 5, 'h1231, 0);
		add_entry(encode(CLASS_ARITH, ALU_CMP, 0, 1, 3, 1, 'h0000), 0, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_ARITH, ALU_ADDC, 6, 1, 3, 1, 'h0000), 0, KIND_WR, 6, 'h1239, 0);
		// Branches. Targets are pc + 4 + imm.
		add_entry(encode(CLASS_BRANCH, ALU_ADD, COND_GT, 0, 0, 0, 'hfff8), 'h320, KIND_BR, 0, 0, 'h31c);
		add_entry(encode(CLASS_BRANCH, ALU_ADD, COND_LT, 0, 0, 0, 'h0010), 'h330, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_ARITH, ALU_CMP, 0, 3, 3, 1, 'h0000), 0, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_BRANCH, ALU_ADD, COND_EQ, 0, 0, 0, 'h0040), 'h200, KIND_BR, 0, 0, 'h244);
		add_entry(encode(CLASS_BRANCH, ALU_ADD, COND_NE, 0, 0, 0, 'h0040), 'h300, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_BRANCH, ALU_ADD, COND_ALWAYS, 0, 0, 0, 'h0100), 'h400, KIND_BR, 0, 0,
				'h504);
		// Stores put r4 at 0x20 and r5 at 0xfc, the last word of the memory.
		add_entry(encode(CLASS_MEM, ALU_ADDC, 0, 3, 4, 0, 'h001b), 0, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_MEM, ALU_ADDC, 0, 0, 5, 0, 'h00fc), 0, KIND_NO, 0, 0, 0);
		add_entry(encode(CLASS_MEM, ALU_ADD, 2, 0, 0, 0, 'h0020), 0, KIND_WR, 2, 'h123a, 0);
		add_entry(encode(CLASS_MEM, ALU_ADD, 3, 0, 0, 0, 'h00fc), 0, KIND_WR, 3, 'h1231, 0);
		add_entry(encode(CLASS_MEM, ALU_ADD, 6, 0, 0, 0, 'h0040), 0, KIND_WR, 6, 'h0, 0);
		// Calls link into r7 whether or not they are taken.
		add_entry(encode(CLASS_MISC, ALU_ADD, COND_ALWAYS, 0, 0, 0, 'h0080), 'h600, KIND_CALL, 7,
				'h604, 'h684);
		add_entry(encode(CLASS_MISC, ALU_ADD, COND_NE, 0, 0, 0, 'h0080), 'h700, KIND_WR, 7, 'h704, 0);
		add_entry(encode(CLASS_ARITH, ALU_PASS, 1, 7, 0, 0, 'h0000), 0, KIND_WR, 1, 'h704, 0);
	endtask

	// Issues one instruction, then watches four idle cycles for its pulses.
	task automatic run_entry(input entry_t e);
		int   branches;
		int   writes;
		logic want_branch;
		logic want_write;
		branches    = 0;
		writes      = 0;
		want_branch = e.kind == KIND_BR || e.kind == KIND_CALL;
		want_write  = e.kind == KIND_WR || e.kind == KIND_CALL;
		instr_valid = 1'b1;
		instr       = e.instr;
		pc          = e.pc;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr       = 32'b0;
		pc          = 32'b0;
		repeat (4) begin
			@(negedge clk);
			if (branch_taken !== 1'b0) begin
				branches++;
				if (!want_branch || branches > 1) begin
					$display("ERROR at %0t: unexpected branch_taken pulse for %h", $time, e.instr);
					stop_run();
				end
				check_branch(branch_taken, branch_target, 1'b1, e.target);
			end
			if (wb_en !== 1'b0) begin
				writes++;
				if (!want_write || writes > 1) begin
					$display("ERROR at %0t: unexpected wb_en pulse for %h", $time, e.instr);
					stop_run();
				end
				check_write(wb_sel, wb_val, e.rd, e.value);
			end
		end
		if (want_branch && branches == 0) begin
			$display("ERROR at %0t: instruction %h never pulsed branch_taken", $time, e.instr);
			stop_run();
		end
		if (want_write && writes == 0) begin
			$display("ERROR at %0t: instruction %h never wrote a register", $time, e.instr);
			stop_run();
		end
		@(posedge clk);
		#1;
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = 32'b0;
		pc          = 32'b0;
		build_entries();
		repeat (16) begin
			@(posedge clk);
			#1;
			check_quiet();
		end
		rst_n = 1'b1;
		repeat (3) begin	// Idle cycles straight after reset.
			@(posedge clk);
			#1;
			check_quiet();
		end
		foreach (entries[i])
			run_entry(entries[i]);
		$display("all tests passed");
		$finish;
	end

endmodule

/* verilog/oldland_core.sv */
`timescale 1ns/1ps

module oldland_core
	import oldland_pkg::*;
#(
	parameter int MEM_WORDS = 64
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  logic [31:0]          instr,
	input  logic [31:0]          pc,
	output logic                 wb_en,
	output logic [reg_sel_w-1:0] wb_sel,
	output logic [31:0]          wb_val,
	output logic                 branch_taken,
	output logic [31:0]          branch_target
);

	logic [reg_sel_w-1:0] ra_read_sel, rb_read_sel;
	logic [31:0]          ra_data, rb_data;

	////////////////////
	// Decode to execute
	////////////////////

	logic [31:0]          ra_val, rb_val, imm32, pc_plus_4;
	logic [reg_sel_w-1:0] rd_sel;
	logic                 update_rd, alu_op1_ra, alu_op2_rb;
	logic                 mem_load, mem_store, is_call, update_flags;
	alu_op_t              alu_opc;
	mem_width_t           mem_width;
	branch_cond_t         branch_condition;
	instr_class_t         instr_class;

	////////////////////
	// Execute to result
	////////////////////

	logic [31:0]          alu_out, wr_val, mar, mdr;
	logic                 wr_result, mem_load_out, mem_store_out;
	logic [reg_sel_w-1:0] rd_sel_out;

	oldland_decode i_decode (.*);

	oldland_regfile i_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_sel  (ra_read_sel),
		.rb_sel  (rb_read_sel),
		.wb_en   (wb_en),
		.wb_sel  (wb_sel),
		.wb_val  (wb_val),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	oldland_exec i_exec (.*);

	oldland_result #(.MEM_WORDS(MEM_WORDS)) i_result (.*);

endmodule

/* verilog/oldland_result.sv */
`timescale 1ns/1ps

module oldland_result
	import oldland_pkg::*;
#(
	parameter int MEM_WORDS = 64
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          alu_out,
	input  logic [31:0]          wr_val,
	input  logic                 wr_result,
	input  logic [reg_sel_w-1:0] rd_sel_out,
	input  logic                 mem_load_out,
	input  logic                 mem_store_out,
	input  logic [31:0]          mar,
	input  logic [31:0]          mdr,
	output logic                 wb_en,
	output logic [reg_sel_w-1:0] wb_sel,
	output logic [31:0]          wb_val
);

	localparam int addr_w = $clog2(MEM_WORDS);

	logic [31:0]       mem [MEM_WORDS];
	logic [29:0]       word_addr;
	logic [addr_w-1:0] mem_index;

	assign word_addr = mar[31:2];
	assign mem_index = word_addr[addr_w-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= 32'b0;
		end else if (mem_store_out) begin
			mem[mem_index] <= mdr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_en <= 1'b0;
		else
			wb_en <= wr_result;	// Stores never request a write.
	end

	always_ff @(posedge clk) begin
		wb_sel <= rd_sel_out;
		wb_val <= mem_load_out ? mem[mem_index] : wr_val;
	end

	// Addresses must be word aligned and inside the memory.
	a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_load_out || mem_store_out) |-> word_addr < MEM_WORDS && mar[1:0] == 2'b00);

endmodule

/* verilog/oldland_exec.sv */
`timescale 1ns/1ps

module oldland_exec
	import oldland_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          ra_val,
	input  logic [31:0]          rb_val,
	input  logic [31:0]          imm32,
	input  logic [31:0]          pc_plus_4,
	input  logic [reg_sel_w-1:0] rd_sel,
	input  logic                 update_rd,
	input  alu_op_t              alu_opc,
	input  logic                 alu_op1_ra,
	input  logic                 alu_op2_rb,
	input  logic                 mem_load,
	input  logic                 mem_store,
	input  mem_width_t           mem_width,
	input  branch_cond_t         branch_condition,
	input  instr_class_t         instr_class,
	input  logic                 is_call,
	input  logic                 update_flags,
	output logic [31:0]          alu_out,
	output logic [31:0]          wr_val,
	output logic                 wr_result,
	output logic [reg_sel_w-1:0] rd_sel_out,
	output logic                 mem_load_out,
	output logic                 mem_store_out,
	output logic [31:0]          mar,
	output logic [31:0]          mdr,
	output logic                 branch_taken,
	output logic [31:0]          branch_target
);

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_q;
	logic        alu_c;
	logic        alu_z;
	logic        cond_met;
	logic        c_flag;
	logic        z_flag;

	assign op1   = alu_op1_ra ? ra_val : pc_plus_4;
	assign op2   = alu_op2_rb ? rb_val : imm32;
	assign alu_z = alu_q == 32'b0;

	////////////////////
	// ALU
	////////////////////

	always_comb begin
		alu_c = 1'b0;
		alu_q = 32'b0;
		case (alu_opc)
		ALU_ADD:  {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ALU_ADDC: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, c_flag};
		ALU_SUB:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_SUBC: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + {32'b0, c_flag};
		ALU_LSL:  {alu_c, alu_q} = {1'b0, op1} << op2[4:0];	// Carry is the last bit out.
		ALU_LSR:  alu_q = op1 >> op2[4:0];
		ALU_AND:  alu_q = op1 & op2;
		ALU_XOR:  alu_q = op1 ^ op2;
		ALU_BIC:  alu_q = op1 & ~(32'd1 << op2[4:0]);
		ALU_BST:  alu_q = op1 | (32'd1 << op2[4:0]);
		ALU_OR:   alu_q = op1 | op2;
		ALU_MOV:  alu_q = op2;
		ALU_CMP:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_ASR:  alu_q = $unsigned($signed(op1) >>> op2[4:0]);
		ALU_PASS: alu_q = op1;
		default:  alu_q = 32'b0;
		endcase
	end

	always_comb begin
		case (branch_condition)
		COND_NE:     cond_met = !z_flag;
		COND_EQ:     cond_met = z_flag;
		COND_GT:     cond_met = !c_flag;
		COND_LT:     cond_met = c_flag;
		COND_ALWAYS: cond_met = 1'b1;
		default:     cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_result     <= 1'b0;
			mem_load_out  <= 1'b0;
			mem_store_out <= 1'b0;
			branch_taken  <= 1'b0;
			c_flag        <= 1'b0;
			z_flag        <= 1'b0;
		end else begin
			wr_result     <= update_rd;
			mem_load_out  <= mem_load;
			mem_store_out <= mem_store;
			branch_taken  <= (instr_class == CLASS_BRANCH || is_call) && cond_met;
			if (update_flags || alu_opc == ALU_CMP) begin
				c_flag <= alu_c;
				z_flag <= alu_z;
			end
		end
	end

	always_ff @(posedge clk) begin
		alu_out    <= alu_q;
		rd_sel_out <= rd_sel;
		wr_val     <= is_call ? pc_plus_4 : alu_q;	// Call links pc plus 4.
		if (mem_load || mem_store)
			mar <= alu_q;
		if (mem_store)
			mdr <= rb_val;
	end

	assign branch_target = alu_out;

	// Decode gives every memory instruction exactly one direction.
	a_one_mem_dir: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_load && mem_store));

endmodule

/* verilog/oldland_decode.sv */
`timescale 1ns/1ps

module oldland_decode
	import oldland_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  logic [31:0]          instr,
	input  logic [31:0]          pc,
	input  logic [31:0]          ra_data,
	input  logic [31:0]          rb_data,
	output logic [reg_sel_w-1:0] ra_read_sel,
	output logic [reg_sel_w-1:0] rb_read_sel,
	output logic [31:0]          ra_val,
	output logic [31:0]          rb_val,
	output logic [31:0]          imm32,
	output logic [31:0]          pc_plus_4,
	output logic [reg_sel_w-1:0] rd_sel,
	output logic                 update_rd,
	output alu_op_t              alu_opc,
	output logic                 alu_op1_ra,
	output logic                 alu_op2_rb,
	output logic                 mem_load,
	output logic                 mem_store,
	output mem_width_t           mem_width,
	output branch_cond_t         branch_condition,
	output instr_class_t         instr_class,
	output logic                 is_call,
	output logic                 update_flags
);

	localparam logic [reg_sel_w-1:0] link_sel = '1;	// Call return address register.

	instr_class_t cls;
	alu_op_t      opc;
	logic         is_arith;
	logic         is_branch;
	logic         is_mem;
	logic         is_misc;
	logic         store_bit;
	logic [31:0]  imm;

	assign cls       = instr_class_t'(instr[31:30]);
	assign opc       = alu_op_t'(instr[29:26]);
	assign is_arith  = cls == CLASS_ARITH;
	assign is_branch = cls == CLASS_BRANCH;
	assign is_mem    = cls == CLASS_MEM;
	assign is_misc   = cls == CLASS_MISC;
	assign store_bit = instr[26];
	assign imm       = {{16{instr[15]}}, instr[15:0]};

	assign ra_read_sel = instr[22:20];
	assign rb_read_sel = instr[19:17];

	////////////////////
	// Control set
	////////////////////

	// Everything but arithmetic uses the adder, for a target or an address.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			update_rd    <= 1'b0;
			mem_load     <= 1'b0;
			mem_store    <= 1'b0;
			is_call      <= 1'b0;
			update_flags <= 1'b0;
			instr_class  <= CLASS_ARITH;
			alu_opc      <= ALU_PASS;
		end else begin
			update_rd    <= instr_valid && ((is_arith && opc != ALU_CMP) ||
					(is_mem && !store_bit) || is_misc);
			mem_load     <= instr_valid && is_mem && !store_bit;
			mem_store    <= instr_valid && is_mem && store_bit;
			is_call      <= instr_valid && is_misc;
			update_flags <= instr_valid && instr[29];
			instr_class  <= instr_valid ? cls : CLASS_ARITH;
			if (!instr_valid)
				alu_opc <= ALU_PASS;	// Idle slot must not touch the flags.
			else
				alu_opc <= is_arith ? opc : ALU_ADD;
		end
	end

	////////////////////
	// Operands
	////////////////////

	always_ff @(posedge clk) begin
		ra_val           <= ra_data;
		rb_val           <= rb_data;
		imm32            <= imm;
		pc_plus_4        <= pc + 32'd4;
		rd_sel           <= is_misc ? link_sel : instr[25:23];
		alu_op1_ra       <= !(is_branch || is_misc);
		alu_op2_rb       <= instr[16];
		mem_width        <= WIDTH_WORD;
		branch_condition <= branch_cond_t'(instr[25:23]);
	end

endmodule

/* verilog/oldland_regfile.sv */
`timescale 1ns/1ps

module oldland_regfile
	import oldland_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [reg_sel_w-1:0] ra_sel,
	input  logic [reg_sel_w-1:0] rb_sel,
	input  logic                 wb_en,
	input  logic [reg_sel_w-1:0] wb_sel,
	input  logic [31:0]          wb_val,
	output logic [31:0]          ra_data,
	output logic [31:0]          rb_data
);

	localparam int num_regs = 1 << reg_sel_w;

	logic [31:0] regs [num_regs];

	// Reads are straight from the flops, so a register written on this
	// edge still shows its old value during the cycle.
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= 32'b0;
		end else if (wb_en) begin
			regs[wb_sel] <= wb_val;
		end
	end

endmodule

/* verilog/oldland_pkg.sv */
package oldland_pkg;

	////////////////////
	// Instruction format
	////////////////////

	// Bits 31..30 of every instruction.
	typedef enum logic [1:0] {
		CLASS_ARITH  = 2'b00,
		CLASS_BRANCH = 2'b01,
		CLASS_MEM    = 2'b10,
		CLASS_MISC   = 2'b11	// Call lives here.
	} instr_class_t;

	// Bits 29..26. Bit 29 doubles as the flag update request.
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_ADDC = 4'b0001,
		ALU_SUB  = 4'b0010,
		ALU_SUBC = 4'b0011,
		ALU_LSL  = 4'b0100,
		ALU_LSR  = 4'b0101,
		ALU_AND  = 4'b0110,
		ALU_XOR  = 4'b0111,
		ALU_BIC  = 4'b1000,
		ALU_BST  = 4'b1001,
		ALU_OR   = 4'b1010,
		ALU_MOV  = 4'b1011,
		ALU_CMP  = 4'b1100,	// Always writes the flags.
		ALU_ASR  = 4'b1110,
		ALU_PASS = 4'b1111
	} alu_op_t;

	// Held in the rd field of a branch or call.
	// Codes not listed here never take the branch.
	typedef enum logic [2:0] {
		COND_NE     = 3'b001,
		COND_EQ     = 3'b010,
		COND_GT     = 3'b011,	// Carry clear.
		COND_LT     = 3'b100,	// Carry set.
		COND_ALWAYS = 3'b111
	} branch_cond_t;

	// Only word accesses are issued today.
	typedef enum logic [1:0] {
		WIDTH_BYTE = 2'b00,
		WIDTH_HALF = 2'b01,
		WIDTH_WORD = 2'b10
	} mem_width_t;

	////////////////////
	// Widths
	////////////////////

	localparam int reg_sel_w = 3;	// Eight registers.

endpackage
